// ==== csrBusPkg.sv ====
// CSR bus definitions
// Bus word layout, register offsets of the video transmitter block
// and the write request handed from the access block to one bank.
package csrBusPkg;

	typedef logic [31:0] usiWord_t;		// address, write and read data
	typedef logic [15:0] csrOfs_t;		// register offset
	typedef logic [7:0] blockId_t;		// block select field

	localparam int cWriteBit = 30;

	//------------------------------------------------------------
	// register offsets
	//------------------------------------------------------------
	localparam csrOfs_t cOfsDmaEnable = 16'h0004;
	localparam csrOfs_t cOfsDmaCycle = 16'h0008;
	localparam csrOfs_t cOfsDmaStart = 16'h000C;
	localparam csrOfs_t cOfsDmaEnd = 16'h0010;
	localparam csrOfs_t cOfsDmaAdd = 16'h0014;
	localparam csrOfs_t cOfsSquareBase = 16'h0200;	// five words per square
	localparam csrOfs_t cOfsSceneColor = 16'h0300;
	localparam csrOfs_t cOfsSceneTiming = 16'h0301;
	localparam csrOfs_t cOfsSceneCtrl = 16'h0302;
	localparam csrOfs_t cOfsSceneStatus = 16'h0303;	// read only
	localparam csrOfs_t cOfsPdpHpos = 16'h0400;
	localparam csrOfs_t cOfsPdpVpos = 16'h0401;

	typedef struct packed
	{
		logic stb;			// one cycle write strobe
		logic [7:0] idx;	// word number inside the bank
		usiWord_t data;
	} csrWrite_t;

endpackage

// ==== videoPkg.sv ====
// Video record types
// Widths of the LCD transmitter settings and the records the
// register banks present to the video pipeline.
package videoPkg;

	typedef logic [15:0] color_t;			// RGB565
	typedef logic signed [11:0] hCoord_t;	// may lie left of the screen
	typedef logic signed [11:0] vCoord_t;
	typedef logic [10:0] hPos_t;
	typedef logic [10:0] vPos_t;
	typedef logic [18:0] dmaAdrs_t;
	typedef logic [6:0] frameTiming_t;

	localparam int cSquareWords = 5;

	//------------------------------------------------------------
	// square descriptor, one word per field
	//------------------------------------------------------------
	typedef struct packed
	{
		color_t color;
		hCoord_t left;
		hCoord_t right;
		vCoord_t top;
		vCoord_t under;
	} square_t;

	typedef enum logic [2:0]
	{
		sqColor = 3'd0,
		sqLeft = 3'd1,
		sqRight = 3'd2,
		sqTop = 3'd3,
		sqUnder = 3'd4
	} squareField_e;

	typedef struct packed
	{
		logic enable;
		logic cycle;			// rearm after each pass
		dmaAdrs_t adrsStart;
		dmaAdrs_t adrsEnd;
		dmaAdrs_t adrsAdd;		// step
	} dmaCfg_t;

	typedef struct packed
	{
		color_t color;
		frameTiming_t timing;
		logic addEn;
		logic subEn;
		logic frameRst;
	} sceneCfg_t;

endpackage

// ==== dmaCsr.sv ====
// DMA setting registers
// Enable, cycle mode and the address window of the frame buffer DMA.
// A done pulse reloads the enable from the cycle-mode bit.
`timescale 1ns/100ps

module dmaCsr (
	input logic iSCLK,
	input logic iSRST,
	input csrBusPkg::csrWrite_t dmaWr,
	input logic iDmaDone,
	output videoPkg::dmaCfg_t dmaCfg
);

//------------------------------------------------------------
// register bank
//------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		dmaCfg.enable <= 1'b0;
		dmaCfg.cycle <= 1'b0;
		dmaCfg.adrsStart <= '0;
		dmaCfg.adrsEnd <= '1;						// whole buffer
		dmaCfg.adrsAdd <= '0;
	end
	else
	begin
		if (dmaWr.stb)
		begin
			case (dmaWr.idx)
				8'd0: dmaCfg.enable <= dmaWr.data[0];
				8'd1: dmaCfg.cycle <= dmaWr.data[0];
				8'd2: dmaCfg.adrsStart <= dmaWr.data[18:0];
				8'd3: dmaCfg.adrsEnd <= dmaWr.data[18:0];
				8'd4: dmaCfg.adrsAdd <= dmaWr.data[18:0];
				default: ;
			endcase
		end

		// done overrides a write to the enable in the same cycle
		if (iDmaDone)
			dmaCfg.enable <= dmaCfg.cycle;			// single shot disarms
	end
end

endmodule

// ==== squareCsr.sv ====
// Square descriptor registers
// Color and four signed edges for each rectangle drawn over the
// picture; one bus word per field, five words per descriptor.
`timescale 1ns/100ps

module squareCsr #(
	parameter int pSquareNum = 7
)(
	input logic iSCLK,
	input logic iSRST,
	input csrBusPkg::csrWrite_t squareWr,
	output videoPkg::square_t [pSquareNum-1:0] square
);

logic [7:0] sqNum;
logic [7:0] sqRem;
videoPkg::squareField_e sqField;

// split the local word number into descriptor and field
assign sqNum = 8'(squareWr.idx / videoPkg::cSquareWords);
assign sqRem = 8'(squareWr.idx % videoPkg::cSquareWords);
assign sqField = videoPkg::squareField_e'(sqRem[2:0]);

//------------------------------------------------------------
// descriptor array
//------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
		square <= '0;
	else if (squareWr.stb)
	begin
		case (sqField)
			videoPkg::sqColor:
				square[sqNum].color <= squareWr.data[15:0];
			videoPkg::sqLeft:
				square[sqNum].left <= squareWr.data[11:0];		// two's complement
			videoPkg::sqRight:
				square[sqNum].right <= squareWr.data[11:0];
			videoPkg::sqTop:
				square[sqNum].top <= squareWr.data[11:0];
			videoPkg::sqUnder:
				square[sqNum].under <= squareWr.data[11:0];
			default: ;
		endcase
	end
end

endmodule

// ==== sceneCsr.sv ====
// Scene change settings
// Fade color, frame timing and the add, subtract and frame reset
// controls of the scene change block.
`timescale 1ns/100ps

module sceneCsr (
	input logic iSCLK,
	input logic iSRST,
	input csrBusPkg::csrWrite_t sceneWr,
	output videoPkg::sceneCfg_t sceneCfg
);

//------------------------------------------------------------
// register bank
//------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		sceneCfg.color <= '0;
		sceneCfg.timing <= '0;
		sceneCfg.addEn <= 1'b0;
		sceneCfg.subEn <= 1'b0;
		sceneCfg.frameRst <= 1'b1;				// hold scene logic in reset
	end
	else if (sceneWr.stb)
	begin
		case (sceneWr.idx)
			8'd0: sceneCfg.color <= sceneWr.data[15:0];
			8'd1: sceneCfg.timing <= sceneWr.data[6:0];	// update rate in frames
			8'd2:
			begin
				sceneCfg.addEn <= sceneWr.data[0];
				sceneCfg.subEn <= sceneWr.data[1];
				sceneCfg.frameRst <= sceneWr.data[2];
			end
			default: ;
		endcase
	end
end

endmodule

// ==== csrAccess.sv ====
// CSR access block
// Decodes the bus address, steers a write to the DMA, square or
// scene bank with a bank-local index, and registers the read data.
`timescale 1ns/100ps

module csrAccess #(
	parameter csrBusPkg::blockId_t pAdrsMap = 8'h04,
	parameter int pSquareNum = 7
)(
	input logic iSCLK,
	input logic iSRST,
	input csrBusPkg::usiWord_t iSUsiAdrs,
	input csrBusPkg::usiWord_t iSUsiWd,
	output csrBusPkg::usiWord_t oSUsiRd,
	output csrBusPkg::csrWrite_t dmaWr,
	output csrBusPkg::csrWrite_t squareWr,
	output csrBusPkg::csrWrite_t sceneWr,
	input videoPkg::dmaCfg_t dmaCfg,
	input videoPkg::square_t [pSquareNum-1:0] square,
	input videoPkg::sceneCfg_t sceneCfg,
	input logic iSceneAlphaMax,
	input logic iSceneAlphaMin,
	input videoPkg::hPos_t iPdpHpos,
	input videoPkg::vPos_t iPdpVpos
);

localparam csrBusPkg::csrOfs_t cOfsSquareEnd =
	csrBusPkg::csrOfs_t'(csrBusPkg::cOfsSquareBase + videoPkg::cSquareWords * pSquareNum);

csrBusPkg::blockId_t blockId;
csrBusPkg::csrOfs_t ofs;
csrBusPkg::csrOfs_t dmaRel, squareRel, sceneRel;
logic blockHit, wrHit;
logic dmaHit, squareHit, sceneHit;
logic [7:0] sqNum, sqRem;
videoPkg::squareField_e sqField;
csrBusPkg::usiWord_t rdNext, rdData;

function automatic csrBusPkg::usiWord_t squareWord(
	input videoPkg::square_t sq,
	input videoPkg::squareField_e field
);
	case (field)
		videoPkg::sqColor: return csrBusPkg::usiWord_t'(sq.color);
		videoPkg::sqLeft: return {{20{sq.left[11]}}, sq.left};
		videoPkg::sqRight: return {{20{sq.right[11]}}, sq.right};
		videoPkg::sqTop: return {{20{sq.top[11]}}, sq.top};
		videoPkg::sqUnder: return {{20{sq.under[11]}}, sq.under};
		default: return '0;
	endcase
endfunction

//------------------------------------------------------------
// address decode
//------------------------------------------------------------
assign blockId = iSUsiAdrs[23:16];
assign ofs = iSUsiAdrs[15:0];
assign blockHit = (blockId == pAdrsMap);
assign wrHit = iSUsiAdrs[csrBusPkg::cWriteBit] && blockHit;

assign dmaRel = ofs - csrBusPkg::cOfsDmaEnable;
assign squareRel = ofs - csrBusPkg::cOfsSquareBase;
assign sceneRel = ofs - csrBusPkg::cOfsSceneColor;

assign dmaHit = (ofs >= csrBusPkg::cOfsDmaEnable) && (ofs <= csrBusPkg::cOfsDmaAdd)
	&& (ofs[1:0] == 2'b00);									// word aligned only
assign squareHit = (ofs >= csrBusPkg::cOfsSquareBase) && (ofs < cOfsSquareEnd);
assign sceneHit = (ofs >= csrBusPkg::cOfsSceneColor) && (ofs <= csrBusPkg::cOfsSceneCtrl);

assign sqNum = 8'(squareRel[7:0] / videoPkg::cSquareWords);
assign sqRem = 8'(squareRel[7:0] % videoPkg::cSquareWords);
assign sqField = videoPkg::squareField_e'(sqRem[2:0]);

always_comb
begin
	dmaWr.stb = wrHit && dmaHit;
	dmaWr.idx = dmaRel[9:2];		// 4 byte stride
	dmaWr.data = iSUsiWd;
	squareWr.stb = wrHit && squareHit;
	squareWr.idx = squareRel[7:0];
	squareWr.data = iSUsiWd;
	sceneWr.stb = wrHit && sceneHit;
	sceneWr.idx = sceneRel[7:0];
	sceneWr.data = iSUsiWd;
end

//------------------------------------------------------------
// read back
//------------------------------------------------------------
always_comb
begin
	rdNext = '0;
	if (blockHit && squareHit)
		rdNext = squareWord(square[sqNum], sqField);
	else if (blockHit)
	begin
		case (ofs)
			csrBusPkg::cOfsDmaEnable: rdNext = {31'd0, dmaCfg.enable};
			csrBusPkg::cOfsDmaCycle: rdNext = {31'd0, dmaCfg.cycle};
			csrBusPkg::cOfsDmaStart: rdNext = csrBusPkg::usiWord_t'(dmaCfg.adrsStart);
			csrBusPkg::cOfsDmaEnd: rdNext = csrBusPkg::usiWord_t'(dmaCfg.adrsEnd);
			csrBusPkg::cOfsDmaAdd: rdNext = csrBusPkg::usiWord_t'(dmaCfg.adrsAdd);
			csrBusPkg::cOfsSceneColor: rdNext = csrBusPkg::usiWord_t'(sceneCfg.color);
			csrBusPkg::cOfsSceneTiming: rdNext = csrBusPkg::usiWord_t'(sceneCfg.timing);
			csrBusPkg::cOfsSceneCtrl:
				rdNext = {29'd0, sceneCfg.frameRst, sceneCfg.subEn, sceneCfg.addEn};
			csrBusPkg::cOfsSceneStatus: rdNext = {30'd0, iSceneAlphaMax, iSceneAlphaMin};
			csrBusPkg::cOfsPdpHpos: rdNext = csrBusPkg::usiWord_t'(iPdpHpos);
			csrBusPkg::cOfsPdpVpos: rdNext = csrBusPkg::usiWord_t'(iPdpVpos);
			default: rdNext = '0;							// unmapped
		endcase
	end
end

always_ff @(posedge iSCLK)
begin
	if (iSRST)
		rdData <= '0;
	else
		rdData <= rdNext;
end

assign oSUsiRd = rdData;

endmodule

// ==== videoTxCsr.sv ====
// Video transmitter CSR slave
// Register bus slave for the LCD transmitter: the access block
// decodes the bus and three banks hold the DMA, square and scene
// settings that drive the video pipeline.
`timescale 1ns/100ps

module videoTxCsr #(
	parameter csrBusPkg::blockId_t pAdrsMap = 8'h04,
	parameter int pSquareNum = 7
)(
	input logic iSCLK,
	input logic iSRST,
	input csrBusPkg::usiWord_t iSUsiAdrs,
	input csrBusPkg::usiWord_t iSUsiWd,
	output csrBusPkg::usiWord_t oSUsiRd,
	input logic iDmaDone,
	output videoPkg::dmaCfg_t oDmaCfg,
	output videoPkg::square_t [pSquareNum-1:0] oSquare,
	output videoPkg::sceneCfg_t oSceneCfg,
	input logic iSceneAlphaMax,
	input logic iSceneAlphaMin,
	input videoPkg::hPos_t iPdpHpos,
	input videoPkg::vPos_t iPdpVpos
);

csrBusPkg::csrWrite_t dmaWr, squareWr, sceneWr;

//------------------------------------------------------------
// bus decode and read back
//------------------------------------------------------------
csrAccess #(
	.pAdrsMap(pAdrsMap),
	.pSquareNum(pSquareNum)
) csrAccess_inst (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.iSUsiAdrs(iSUsiAdrs),
	.iSUsiWd(iSUsiWd),
	.oSUsiRd(oSUsiRd),
	.dmaWr(dmaWr),
	.squareWr(squareWr),
	.sceneWr(sceneWr),
	.dmaCfg(oDmaCfg),
	.square(oSquare),
	.sceneCfg(oSceneCfg),
	.iSceneAlphaMax(iSceneAlphaMax),
	.iSceneAlphaMin(iSceneAlphaMin),
	.iPdpHpos(iPdpHpos),
	.iPdpVpos(iPdpVpos)
);

//------------------------------------------------------------
// register banks
//------------------------------------------------------------
dmaCsr dmaCsr_inst (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.dmaWr(dmaWr),
	.iDmaDone(iDmaDone),
	.dmaCfg(oDmaCfg)
);

squareCsr #(
	.pSquareNum(pSquareNum)
) squareCsr_inst (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.squareWr(squareWr),
	.square(oSquare)
);

sceneCsr sceneCsr_inst (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.sceneWr(sceneWr),
	.sceneCfg(oSceneCfg)
);

endmodule

// ==== videoTxCsrTb.sv ====
// Testbench for the video transmitter CSR slave
// Drives register bus cycles, keeps a model of every write and
// checks read-back and the record outputs against it.
`timescale 1ns/100ps

module videoTxCsrTb;

localparam csrBusPkg::blockId_t cAdrsMap = 8'h04;
localparam int cSquareNum = 7;

logic iSCLK = 1'b0;
logic iSRST;
csrBusPkg::usiWord_t iSUsiAdrs, iSUsiWd, oSUsiRd;
logic iDmaDone;
videoPkg::dmaCfg_t oDmaCfg;
videoPkg::square_t [cSquareNum-1:0] oSquare;
videoPkg::sceneCfg_t oSceneCfg;
logic iSceneAlphaMax, iSceneAlphaMin;
videoPkg::hPos_t iPdpHpos;
videoPkg::vPos_t iPdpVpos;

videoPkg::dmaCfg_t mDma;							// reference model
videoPkg::square_t [cSquareNum-1:0] mSquare;
videoPkg::sceneCfg_t mScene;

integer seed = 32'h1373f338;
int errCount = 0;
int checkCount = 0;
logic portCheckOn = 1'b0;

videoTxCsr #(
	.pAdrsMap(cAdrsMap),
	.pSquareNum(cSquareNum)
) videoTxCsr_inst (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.iSUsiAdrs(iSUsiAdrs),
	.iSUsiWd(iSUsiWd),
	.oSUsiRd(oSUsiRd),
	.iDmaDone(iDmaDone),
	.oDmaCfg(oDmaCfg),
	.oSquare(oSquare),
	.oSceneCfg(oSceneCfg),
	.iSceneAlphaMax(iSceneAlphaMax),
	.iSceneAlphaMin(iSceneAlphaMin),
	.iPdpHpos(iPdpHpos),
	.iPdpVpos(iPdpVpos)
);

always #4 iSCLK = ~iSCLK;

function automatic csrBusPkg::usiWord_t busAdrs(input logic wr, input csrBusPkg::blockId_t blk,
	input csrBusPkg::csrOfs_t ofs);
	return {1'b0, wr, 6'd0, blk, ofs};
endfunction

//------------------------------------------------------------
// reference model
//------------------------------------------------------------
function automatic csrBusPkg::usiWord_t expRead(input csrBusPkg::csrOfs_t ofs);
	int n;
	int f;
	n = (int'(ofs) - 'h200) / 5;
	f = (int'(ofs) - 'h200) % 5;
	if (int'(ofs) >= 'h200 && int'(ofs) < 'h200 + 5 * cSquareNum)
	begin
		case (f)
			0: return 32'(mSquare[n].color);
			1: return int'(mSquare[n].left);		// sign extended
			2: return int'(mSquare[n].right);
			3: return int'(mSquare[n].top);
			default: return int'(mSquare[n].under);
		endcase
	end
	case (ofs)
		16'h004: return 32'(mDma.enable);
		16'h008: return 32'(mDma.cycle);
		16'h00C: return 32'(mDma.adrsStart);
		16'h010: return 32'(mDma.adrsEnd);
		16'h014: return 32'(mDma.adrsAdd);
		16'h300: return 32'(mScene.color);
		16'h301: return 32'(mScene.timing);
		16'h302: return {29'd0, mScene.frameRst, mScene.subEn, mScene.addEn};
		16'h303: return {30'd0, iSceneAlphaMax, iSceneAlphaMin};
		16'h400: return 32'(iPdpHpos);
		16'h401: return 32'(iPdpVpos);
		default: return '0;
	endcase
endfunction

task automatic modelWrite(input csrBusPkg::csrOfs_t ofs, input csrBusPkg::usiWord_t data);
	int n;
	int f;
	n = (int'(ofs) - 'h200) / 5;
	f = (int'(ofs) - 'h200) % 5;
	if (int'(ofs) >= 'h200 && int'(ofs) < 'h200 + 5 * cSquareNum)
	begin
		case (f)
			0: mSquare[n].color = data[15:0];
			1: mSquare[n].left = data[11:0];
			2: mSquare[n].right = data[11:0];
			3: mSquare[n].top = data[11:0];
			default: mSquare[n].under = data[11:0];
		endcase
	end
	else
	begin
		case (ofs)
			16'h004: mDma.enable = data[0];
			16'h008: mDma.cycle = data[0];
			16'h00C: mDma.adrsStart = data[18:0];
			16'h010: mDma.adrsEnd = data[18:0];
			16'h014: mDma.adrsAdd = data[18:0];
			16'h300: mScene.color = data[15:0];
			16'h301: mScene.timing = data[6:0];
			16'h302: {mScene.frameRst, mScene.subEn, mScene.addEn} = data[2:0];
			default: ;
		endcase
	end
endtask

//------------------------------------------------------------
// bus tasks
//------------------------------------------------------------
task automatic busWrite(input csrBusPkg::blockId_t blk, input csrBusPkg::csrOfs_t ofs,
	input csrBusPkg::usiWord_t data);
	@(posedge iSCLK);
	iSUsiAdrs <= busAdrs(1'b1, blk, ofs);
	iSUsiWd <= data;
	@(posedge iSCLK);							// DUT takes the write here
	iSUsiAdrs <= '0;
	iSUsiWd <= '0;
	if (blk == cAdrsMap)
		modelWrite(ofs, data);
endtask

task automatic busRead(input csrBusPkg::blockId_t blk, input csrBusPkg::csrOfs_t ofs,
	input csrBusPkg::usiWord_t expVal);
	@(posedge iSCLK);
	iSUsiAdrs <= busAdrs(1'b0, blk, ofs);
	@(posedge iSCLK);
	iSUsiAdrs <= '0;
	@(negedge iSCLK);
	checkCount++;
	assert (oSUsiRd === expVal)
	else
	begin
		$display("Error: oSUsiRd at offset %h read %h expected %h", ofs, oSUsiRd, expVal);
		errCount++;
	end
endtask

task automatic checkMapped();
	int i;
	for (i = 0; i < 5; i++)
		busRead(cAdrsMap, 16'(4 + 4 * i), expRead(16'(4 + 4 * i)));
	for (i = 0; i < 5 * cSquareNum; i++)
		busRead(cAdrsMap, 16'('h200 + i), expRead(16'('h200 + i)));
	for (i = 0; i < 4; i++)
		busRead(cAdrsMap, 16'('h300 + i), expRead(16'('h300 + i)));
	busRead(cAdrsMap, 16'h400, expRead(16'h400));
	busRead(cAdrsMap, 16'h401, expRead(16'h401));
endtask

task automatic pulseDone(input logic withEnWrite);
	@(posedge iSCLK);
	iDmaDone <= 1'b1;
	if (withEnWrite)
	begin
		iSUsiAdrs <= busAdrs(1'b1, cAdrsMap, 16'h004);
		iSUsiWd <= 32'h1;
	end
	@(posedge iSCLK);
	iDmaDone <= 1'b0;
	iSUsiAdrs <= '0;
	iSUsiWd <= '0;
	if (withEnWrite)
		modelWrite(16'h004, 32'h1);
	mDma.enable = mDma.cycle;					// done wins over the write
endtask

// output records follow the model one cycle after each write
always @(negedge iSCLK)
begin
	if (portCheckOn)
	begin
		checkCount++;
		assert (oDmaCfg === mDma)
		else
		begin
			$display("Error: oDmaCfg %h expected %h", oDmaCfg, mDma);
			errCount++;
		end
		assert (oSquare === mSquare)
		else
		begin
			$display("Error: oSquare %h expected %h", oSquare, mSquare);
			errCount++;
		end
		assert (oSceneCfg === mScene)
		else
		begin
			$display("Error: oSceneCfg %h expected %h", oSceneCfg, mScene);
			errCount++;
		end
	end
end

initial
begin
	int i;
	csrBusPkg::usiWord_t data;
	mDma = '0;
	mDma.adrsEnd = '1;
	mSquare = '0;
	mScene = '0;
	mScene.frameRst = 1'b1;
	iSRST = 1'b1;
	iSUsiAdrs = '0;
	iSUsiWd = '0;
	iDmaDone = 1'b0;
	iSceneAlphaMax = 1'b0;
	iSceneAlphaMin = 1'b0;
	iPdpHpos = '0;
	iPdpVpos = '0;
	for (i = 0; i < 16; i++)
		@(posedge iSCLK);
	iSRST <= 1'b0;
	portCheckOn = 1'b1;
	@(negedge iSCLK);

	// reset values
	checkCount++;
	assert (oSceneCfg.frameRst === 1'b1 && oSceneCfg.addEn === 1'b0 && oSceneCfg.subEn === 1'b0)
	else
	begin
		$display("Error: oSceneCfg control bits %h expected 4",
			{oSceneCfg.frameRst, oSceneCfg.subEn, oSceneCfg.addEn});
		errCount++;
	end
	checkMapped();

	for (i = 0; i < 5; i++)
	begin
		data = $random(seed);
		busWrite(cAdrsMap, 16'(4 + 4 * i), data);
		busRead(cAdrsMap, 16'(4 + 4 * i), expRead(16'(4 + 4 * i)));
	end

	// done reload: single shot, cyclic, done against enable write
	busWrite(cAdrsMap, 16'h008, 32'h0);
	busWrite(cAdrsMap, 16'h004, 32'h1);
	pulseDone(1'b0);
	busRead(cAdrsMap, 16'h004, 32'h0);
	busWrite(cAdrsMap, 16'h008, 32'h1);
	busWrite(cAdrsMap, 16'h004, 32'h1);
	pulseDone(1'b0);
	busRead(cAdrsMap, 16'h004, 32'h1);
	busWrite(cAdrsMap, 16'h008, 32'h0);
	pulseDone(1'b1);
	busRead(cAdrsMap, 16'h004, 32'h0);

	for (i = 0; i < 5 * cSquareNum; i++)
	begin
		data = $random(seed);
		if (i % 5 == 1)
			data[11] = 1'b1;						// negative left edge
		busWrite(cAdrsMap, 16'('h200 + i), data);
	end
	checkMapped();

	// scene controls and status
	busWrite(cAdrsMap, 16'h300, $random(seed));
	busWrite(cAdrsMap, 16'h301, $random(seed));
	busWrite(cAdrsMap, 16'h302, 32'h3);
	busRead(cAdrsMap, 16'h302, 32'h3);
	@(posedge iSCLK);
	iSceneAlphaMax <= 1'b1;
	iPdpHpos <= 11'($random(seed));
	iPdpVpos <= 11'($random(seed));
	busRead(cAdrsMap, 16'h303, 32'h2);
	busRead(cAdrsMap, 16'h400, expRead(16'h400));
	busRead(cAdrsMap, 16'h401, expRead(16'h401));
	@(posedge iSCLK);
	iSceneAlphaMax <= 1'b0;
	iSceneAlphaMin <= 1'b1;
	busRead(cAdrsMap, 16'h303, 32'h1);

	// foreign block and unmapped offsets
	busWrite(cAdrsMap ^ 8'h01, 16'h300, 32'hFFFF);
	busWrite(cAdrsMap ^ 8'h10, 16'h00C, 32'h1234);
	checkMapped();
	busRead(cAdrsMap ^ 8'h01, 16'h300, 32'h0);
	busRead(cAdrsMap, 16'h000, 32'h0);
	busRead(cAdrsMap, 16'h006, 32'h0);
	busRead(cAdrsMap, 16'h018, 32'h0);
	busRead(cAdrsMap, 16'('h200 + 5 * cSquareNum), 32'h0);
	busRead(cAdrsMap, 16'h304, 32'h0);
	busRead(cAdrsMap, 16'h402, 32'h0);

	@(posedge iSCLK);
	portCheckOn = 1'b0;
	$display("checks %0d, errors %0d", checkCount, errCount);
	if (errCount == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

// ==== compile.f ====
csrBusPkg.sv
videoPkg.sv
dmaCsr.sv
squareCsr.sv
sceneCsr.sv
csrAccess.sv
videoTxCsr.sv
videoTxCsrTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the CSR slave testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module videoTxCsrTb -o videoTxCsrSim
./obj_dir/videoTxCsrSim | tee sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0
